// File: hdl/calc_pkg.sv
`default_nettype none

package calc_pkg;

    // Operand and result width, also the step count of both units
    localparam int DATA_W = 16;

    // Width of the per-unit bit counter
    localparam int CNT_W = $clog2(DATA_W);

    // Operator latched by the controller
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MUL = 2'd2
    } op_t;

    // Operand pair handed to an execution unit
    typedef struct packed {
        logic [DATA_W-1:0] a; // First operand
        logic [DATA_W-1:0] b; // Second operand
    } calc_req_t;

endpackage

`default_nettype wire

// File: hdl/keypad_entry.sv
`timescale 1ns/1ps
`default_nettype none

module keypad_entry (
    input  logic                       clk,
    input  logic                       nRST,
    input  logic [3:0]                 keypad_input,
    input  logic                       read_input,
    input  logic                       entry_en,
    input  logic                       entry_clear,
    output logic [calc_pkg::DATA_W-1:0] entry_value
);
    import calc_pkg::*;

    logic              digit_ok;   // Code is a decimal digit
    logic              take_digit;
    logic [DATA_W-1:0] times_ten;
    logic [DATA_W-1:0] next_value;

    assign digit_ok   = (keypad_input <= 4'd9);
    assign take_digit = read_input && entry_en && digit_ok;

    // value*10 = value*8 + value*2, wraps at the operand width
    assign times_ten  = (entry_value << 3) + (entry_value << 1);
    assign next_value = times_ten + DATA_W'(keypad_input);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            entry_value <= '0;
        end else if (entry_clear) begin
            entry_value <= '0;         // Clear wins over a digit
        end else if (take_digit) begin
            entry_value <= next_value;
        end
    end

endmodule

`default_nettype wire

// File: hdl/calc_controller.sv
`timescale 1ns/1ps
`default_nettype none

module calc_controller (
    input  logic                        clk,
    input  logic                        nRST,
    input  logic [2:0]                  operator_input,
    input  logic                        equal_input,
    input  logic [calc_pkg::DATA_W-1:0] entry_value,
    output logic                        entry_en,
    output logic                        entry_clear,
    output calc_pkg::calc_req_t         req,
    output logic                        sub,
    output logic                        add_start,
    input  logic                        add_finish,
    input  logic [calc_pkg::DATA_W-1:0] add_result,
    output logic                        mul_start,
    input  logic                        mul_finish,
    input  logic [calc_pkg::DATA_W-1:0] mul_result,
    output logic                        complete,
    output logic [calc_pkg::DATA_W-1:0] display_output
);
    import calc_pkg::*;

    typedef enum logic [2:0] {
        S_FIRST,  // Typing operand one
        S_SECOND, // Typing operand two
        S_ISSUE,  // Start pulse to a unit
        S_WAIT,   // Unit running
        S_SHOW    // Result on display
    } state_t;

    state_t            state, next_state;
    op_t               op, op_dec;
    logic              op_valid;
    logic              take_op;
    logic              take_eq;
    logic              unit_done;
    logic [DATA_W-1:0] unit_result;

    // One-hot operator decode, anything else is ignored
    always_comb begin
        op_valid = 1'b1;
        op_dec   = OP_ADD;
        case (operator_input)
            3'b001:  op_dec = OP_ADD;
            3'b010:  op_dec = OP_SUB;
            3'b100:  op_dec = OP_MUL;
            default: op_valid = 1'b0;
        endcase
    end

    assign take_op = (state == S_FIRST) && op_valid;
    assign take_eq = (state == S_SECOND) && equal_input;

    assign unit_done   = (op == OP_MUL) ? mul_finish : add_finish;
    assign unit_result = (op == OP_MUL) ? mul_result : add_result;

    assign entry_en    = (state == S_FIRST) || (state == S_SECOND);
    assign entry_clear = take_op || (state == S_SHOW);
    assign sub         = (op == OP_SUB);
    assign add_start   = (state == S_ISSUE) && (op != OP_MUL);
    assign mul_start   = (state == S_ISSUE) && (op == OP_MUL);

    always_comb begin
        next_state = state;
        case (state)
            S_FIRST:  if (take_op) next_state = S_SECOND;
            S_SECOND: if (take_eq) next_state = S_ISSUE;
            S_ISSUE:  next_state = S_WAIT;
            S_WAIT:   if (unit_done) next_state = S_SHOW;
            S_SHOW:   next_state = S_FIRST;
            default:  next_state = S_FIRST;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= S_FIRST;
            op             <= OP_ADD;
            complete       <= 1'b0;
            display_output <= '0;
        end else begin
            state    <= next_state;
            complete <= (state == S_WAIT) && unit_done; // High only in S_SHOW
            if (take_op) begin
                op <= op_dec;
            end
            if ((state == S_WAIT) && unit_done) begin
                display_output <= unit_result;
            end
        end
    end

    // Operand one at the operator key, operand two at equals
    always_ff @(posedge clk) begin
        if (take_op) begin
            req.a <= entry_value;
        end
        if (take_eq) begin
            req.b <= entry_value;
        end
    end

endmodule

`default_nettype wire

// File: hdl/serial_addsub.sv
`timescale 1ns/1ps
`default_nettype none

module serial_addsub (
    input  logic                        clk,
    input  logic                        nRST,
    input  calc_pkg::calc_req_t         req,
    input  logic                        sub,
    input  logic                        start,
    output logic [calc_pkg::DATA_W-1:0] result,
    output logic                        finish
);
    import calc_pkg::*;

    logic [DATA_W-1:0] a_sr;
    logic [DATA_W-1:0] b_sr;
    logic [DATA_W-1:0] res_sr;
    logic              carry;
    logic              busy;
    logic [CNT_W-1:0]  cnt;
    logic              load;
    logic              last;
    logic              sum_bit;
    logic              carry_out;

    assign load = start && !busy;
    assign last = (cnt == CNT_W'(DATA_W - 1));

    // Full adder on the current LSBs
    assign sum_bit   = a_sr[0] ^ b_sr[0] ^ carry;
    assign carry_out = (a_sr[0] & b_sr[0]) | (carry & (a_sr[0] ^ b_sr[0]));

    // Top bit comes straight from the adder in the final step
    assign finish = busy && last;
    assign result = {sum_bit, res_sr[DATA_W-1:1]};

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy  <= 1'b0;
            cnt   <= '0;
            carry <= 1'b0;
        end else if (load) begin
            busy  <= 1'b1;
            cnt   <= '0;
            carry <= sub;              // +1 of two's complement
        end else if (busy) begin
            carry <= carry_out;
            cnt   <= cnt + 1'b1;
            if (last) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            a_sr <= req.a;
            b_sr <= sub ? ~req.b : req.b;
        end else if (busy) begin
            a_sr   <= a_sr >> 1;
            b_sr   <= b_sr >> 1;
            res_sr <= {sum_bit, res_sr[DATA_W-1:1]}; // LSB first
        end
    end

endmodule

`default_nettype wire

// File: hdl/shift_add_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module shift_add_multiplier (
    input  logic                        clk,
    input  logic                        nRST,
    input  calc_pkg::calc_req_t         req,
    input  logic                        start,
    output logic [calc_pkg::DATA_W-1:0] result,
    output logic                        finish
);
    import calc_pkg::*;

    logic [DATA_W-1:0] mcand;      // Multiplicand, shifted left each step
    logic [DATA_W-1:0] mplr;       // Multiplier, shifted right each step
    logic [DATA_W-1:0] acc;
    logic [DATA_W-1:0] partial;
    logic              busy;
    logic [CNT_W-1:0]  cnt;
    logic              load;
    logic              last;

    assign load = start && !busy;
    assign last = (cnt == CNT_W'(DATA_W - 1));

    // Add the shifted multiplicand when the multiplier bit is set
    assign partial = acc + (mplr[0] ? mcand : '0);

    assign finish = busy && last;
    assign result = partial;       // Low bits only, carries out are dropped

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (load) begin
            busy <= 1'b1;
            cnt  <= '0;
        end else if (busy) begin
            cnt <= cnt + 1'b1;
            if (last) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            mcand <= req.a;
            mplr  <= req.b;
            acc   <= '0;
        end else if (busy) begin
            acc   <= partial;
            mcand <= mcand << 1;
            mplr  <= mplr >> 1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/calc_top.sv
`timescale 1ns/1ps
`default_nettype none

module calc_top (
    input  logic                        clk,
    input  logic                        nRST,
    input  logic [3:0]                  keypad_input,
    input  logic                        read_input,
    input  logic [2:0]                  operator_input,
    input  logic                        equal_input,
    output logic                        complete,
    output logic [calc_pkg::DATA_W-1:0] display_output
);
    import calc_pkg::*;

    logic              entry_en;
    logic              entry_clear;
    logic [DATA_W-1:0] entry_value;
    calc_req_t         req;        // Shared by both units
    logic              sub;
    logic              add_start;
    logic              add_finish;
    logic [DATA_W-1:0] add_result;
    logic              mul_start;
    logic              mul_finish;
    logic [DATA_W-1:0] mul_result;

    keypad_entry u_entry (
        .clk          (clk),
        .nRST         (nRST),
        .keypad_input (keypad_input),
        .read_input   (read_input),
        .entry_en     (entry_en),
        .entry_clear  (entry_clear),
        .entry_value  (entry_value)
    );

    calc_controller u_ctrl (
        .clk            (clk),
        .nRST           (nRST),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .entry_value    (entry_value),
        .entry_en       (entry_en),
        .entry_clear    (entry_clear),
        .req            (req),
        .sub            (sub),
        .add_start      (add_start),
        .add_finish     (add_finish),
        .add_result     (add_result),
        .mul_start      (mul_start),
        .mul_finish     (mul_finish),
        .mul_result     (mul_result),
        .complete       (complete),
        .display_output (display_output)
    );

    serial_addsub u_addsub (
        .clk    (clk),
        .nRST   (nRST),
        .req    (req),
        .sub    (sub),
        .start  (add_start),
        .result (add_result),
        .finish (add_finish)
    );

    shift_add_multiplier u_mul (
        .clk    (clk),
        .nRST   (nRST),
        .req    (req),
        .start  (mul_start),
        .result (mul_result),
        .finish (mul_finish)
    );

endmodule

`default_nettype wire

// File: tests/calc_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module calc_assertions (
    input logic clk,
    input logic nRST,
    input logic complete,
    input logic add_start,
    input logic add_finish,
    input logic add_busy,
    input logic mul_start,
    input logic mul_finish,
    input logic mul_busy
);
    int fail_count = 0;

    a_complete_pulse: assert property (@(posedge clk) disable iff (!nRST)
        complete |=> !complete)
        else begin fail_count++; $error("complete held longer than one cycle"); end

    a_add_latency: assert property (@(posedge clk) disable iff (!nRST)
        add_start |-> ##16 add_finish)
        else begin fail_count++; $error("adder finish not 16 cycles after start"); end

    a_mul_latency: assert property (@(posedge clk) disable iff (!nRST)
        mul_start |-> ##16 mul_finish)
        else begin fail_count++; $error("multiplier finish not 16 cycles after start"); end

    a_add_idle: assert property (@(posedge clk) disable iff (!nRST)
        add_start |-> !add_busy)
        else begin fail_count++; $error("adder started while busy"); end

    a_mul_idle: assert property (@(posedge clk) disable iff (!nRST)
        mul_start |-> !mul_busy)
        else begin fail_count++; $error("multiplier started while busy"); end

    // Only one unit per calculation
    a_one_start: assert property (@(posedge clk) disable iff (!nRST)
        !(add_start && mul_start))
        else begin fail_count++; $error("both units started together"); end

    a_reset_quiet: assert property (@(posedge clk) !nRST |-> !complete)
        else begin fail_count++; $error("complete high during reset"); end

endmodule

bind calc_top calc_assertions u_assertions (
    .clk        (clk),
    .nRST       (nRST),
    .complete   (complete),
    .add_start  (add_start),
    .add_finish (add_finish),
    .add_busy   (u_addsub.busy),
    .mul_start  (mul_start),
    .mul_finish (mul_finish),
    .mul_busy   (u_mul.busy)
);

`default_nettype wire

// File: tests/calc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module calc_tb;
    import calc_pkg::*;

    localparam logic [31:0] SEED       = 32'hd202_7928;
    localparam int          LATENCY    = 18; // Equals drive edge to complete
    localparam int          WAIT_LIMIT = 40;

    logic              clk;
    logic              nRST;
    logic [3:0]        keypad_input;
    logic              read_input;
    logic [2:0]        operator_input;
    logic              equal_input;
    logic              complete;
    logic [DATA_W-1:0] display_output;
    logic [31:0]       lfsr;

    calc_top dut (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .complete       (complete),
        .display_output (display_output)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(negedge clk) begin
        if (dut.u_assertions.fail_count != 0) begin
            fail_now("a bound assertion on the DUT failed");
        end
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "stopped at the first error");
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic int rand_bits(input int n);
        int   v;
        logic fb;
        v = 0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = (v << 1) | int'(fb);
        end
        return v;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic press_key(input logic [3:0] code);
        keypad_input = code;
        read_input   = 1'b1;
        next_cycle();
        read_input   = 1'b0;
    endtask

    // Expected operand follows value*10 + digit modulo 2^16
    task automatic enter_number(input int ndigits, input bit lead, input bit junk,
                                output logic [DATA_W-1:0] value);
        int digit;
        value = '0;
        for (int i = 0; i < ndigits; i++) begin
            if (junk) begin
                press_key(4'(10 + rand_bits(3) % 6)); // Non-decimal code
            end
            digit = (lead && i == 0) ? 1 + rand_bits(4) % 9 : rand_bits(4) % 10;
            press_key(4'(digit));
            value = value * 16'd10 + 16'(digit);
        end
    endtask

    task automatic press_operator(input op_t op, input bit junk);
        if (junk) begin
            operator_input = rand_bits(1) ? 3'b011 : 3'b110; // Not one-hot
            next_cycle();
        end
        operator_input = (op == OP_SUB) ? 3'b010 : (op == OP_MUL) ? 3'b100 : 3'b001;
        next_cycle();
        operator_input = 3'b000;
    endtask

    task automatic model_result(input op_t op, input logic [DATA_W-1:0] a,
                                input logic [DATA_W-1:0] b, output logic [DATA_W-1:0] r);
        case (op)
            OP_SUB:  r = a - b;
            OP_MUL:  r = a * b;   // Low 16 bits of the product
            default: r = a + b;
        endcase
    endtask

    // Random keys while a unit runs
    task automatic drive_noise(input bit on);
        equal_input    = on ? 1'(rand_bits(1)) : 1'b0;
        read_input     = on ? 1'(rand_bits(1)) : 1'b0;
        keypad_input   = 4'(rand_bits(4));
        operator_input = on ? 3'b001 << (rand_bits(2) % 3) : 3'b000;
    endtask

    task automatic run_calc(input op_t op, input bit lead, input bit junk, input bit noise);
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] expected;
        int                na;
        int                nb;
        int                cycles;
        na = lead ? 1 + rand_bits(2) % 3 : 1 + rand_bits(3) % 5;
        nb = lead ? 4 : 1 + rand_bits(3) % 5; // Four digits beat three
        enter_number(na, 1'b0, junk, a);
        press_operator(op, junk);
        enter_number(nb, lead, junk, b);
        model_result(op, a, b, expected);
        equal_input = 1'b1;
        cycles      = 0;
        do begin
            next_cycle();
            cycles++;
            assert (dut.entry_value == b)
                else fail_now($sformatf("error: time %0t entry %0d changed while busy, expected %0d",
                                        $time, dut.entry_value, b));
            drive_noise(noise && cycles < 15);
            if (!complete && cycles >= WAIT_LIMIT) begin
                fail_now($sformatf("timeout: no complete within %0d cycles of equals",
                                   WAIT_LIMIT));
            end
        end while (!complete);
        assert (cycles == LATENCY)
            else fail_now($sformatf("error: time %0t complete after %0d cycles, expected %0d",
                                    $time, cycles, LATENCY));
        assert (display_output == expected)
            else fail_now($sformatf("error: time %0t op %s a %0d b %0d display %0d expected %0d",
                                    $time, op.name(), a, b, display_output, expected));
        next_cycle(); // Controller back to first operand
    endtask

    initial begin
        lfsr           = SEED;
        nRST           = 1'b0;
        keypad_input   = 4'd0;
        read_input     = 1'b0;
        operator_input = 3'b000;
        equal_input    = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        nRST = 1'b1;
        assert (!complete && display_output == '0 && dut.entry_value == '0)
            else fail_now($sformatf("error: time %0t outputs not cleared by reset", $time));
        repeat (6) run_calc(OP_ADD, 1'b0, 1'b0, 1'b0);
        repeat (6) run_calc(OP_SUB, 1'b1, 1'b0, 1'b0);
        repeat (6) run_calc(OP_MUL, 1'b0, 1'b0, 1'b0);
        repeat (4) run_calc(op_t'(2'(rand_bits(2) % 3)), 1'b0, 1'b1, 1'b0);
        repeat (4) run_calc(op_t'(2'(rand_bits(2) % 3)), 1'b0, 1'b0, 1'b1);
        if (dut.u_assertions.fail_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            fail_now("a bound assertion on the DUT failed");
        end
    end

endmodule

`default_nettype wire

// File: calc.f
hdl/calc_pkg.sv
hdl/keypad_entry.sv
hdl/calc_controller.sv
hdl/serial_addsub.sv
hdl/shift_add_multiplier.sv
hdl/calc_top.sv
tests/calc_assertions.sv
tests/calc_tb.sv

// File: Makefile
SIM        = verilator
TOP        = calc_tb
FILELIST   = calc.f
OBJ_DIR    = obj_dir
FLAGS      = --binary --timing --assert --Mdir $(OBJ_DIR)
LINT_FLAGS = --lint-only --timing -Wall
RUN_ARGS   = +verilator+error+limit+100
LOG        = sim.log
PASS_MSG   = Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
